// ==== compile.f ====
rtl/qdr_pkg.sv
rtl/qdr_train_if.sv
rtl/qdr_bit_train.sv
rtl/qdr_cal_ctrl.sv
rtl/qdr_read_align.sv
rtl/qdr_phy_cal.sv
testbench/qdr_delay_model.sv
testbench/tb_qdr_phy_cal.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the calibration testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f compile.f --top-module tb_qdr_phy_cal -o sim_tb \
  > build.log 2>&1 && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log 2>/dev/null && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }

// ==== testbench/tb_qdr_phy_cal.sv ====
`timescale 1ns/1ps

module tb_qdr_phy_cal import qdr_pkg::*; ();

  localparam int start_slack = capture_lag + acquire_threshold + 8;
  localparam int cal_timeout = 200000;
  localparam int read_cycles = 40;
  // Lowest edge with enough stable taps below it to lock the first reading
  localparam int low_edge = 4;

  logic clk;
  logic reset;
  logic rd_valid_in;
  logic use_model;
  logic [data_width-1:0] drv_rise;
  logic [data_width-1:0] drv_fall;
  logic [data_width-1:0] model_rise;
  logic [data_width-1:0] model_fall;
  logic [data_width-1:0] q_rise;
  logic [data_width-1:0] q_fall;
  logic [data_width-1:0] dly_en;
  logic [data_width-1:0] dly_inc_dec_n;
  logic [data_width-1:0] dly_rst;
  logic [data_width-1:0] aligned;
  logic [data_width-1:0] rd_rise;
  logic [data_width-1:0] rd_fall;
  logic [data_width-1:0] exp_aligned;
  logic cal_done;
  logic cal_fail;
  logic rd_valid_out;
  logic [31:0] lfsr;
  int edge_pos [data_width];

  // Capture data comes from the delay model during training
  assign q_rise = use_model ? model_rise : drv_rise;
  assign q_fall = use_model ? model_fall : drv_fall;

  qdr_phy_cal UUT (
    .clk           (clk),
    .reset         (reset),
    .q_rise        (q_rise),
    .q_fall        (q_fall),
    .rd_valid_in   (rd_valid_in),
    .dly_en        (dly_en),
    .dly_inc_dec_n (dly_inc_dec_n),
    .dly_rst       (dly_rst),
    .cal_done      (cal_done),
    .cal_fail      (cal_fail),
    .aligned       (aligned),
    .rd_rise       (rd_rise),
    .rd_fall       (rd_fall),
    .rd_valid_out  (rd_valid_out)
  );

  qdr_delay_model dly_model (
    .clk           (clk),
    .dly_en        (dly_en),
    .dly_inc_dec_n (dly_inc_dec_n),
    .dly_rst       (dly_rst),
    .edge_pos      (edge_pos),
    .q_rise        (model_rise),
    .q_fall        (model_fall)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic random_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic flag_mismatch(input string msg);
    abort_run($sformatf("[FAIL] %0t: %s", $time, msg));
  endtask

  task automatic run_calibration(input int bad_bit);
    int r;
    int cyc;
    int tap;
    logic seen_rst;
    logic started;
    for (int b = 0; b < data_width; b++) begin
      random_bits(5, r);
      if (b == bad_bit) begin
        edge_pos[b] = tap_max + 20;
      end else if (b % 3 == 0) begin
        // No whole bit fits below a low edge, so the eye above it is used
        edge_pos[b] = low_edge + r % (bit_steps + 1 - low_edge);
      end else begin
        edge_pos[b] = bit_steps + 1 + r;
      end
    end
    @(posedge clk);
    #1;
    reset = 1'b1;
    use_model = 1'b1;
    rd_valid_in = 1'b0;
    // The first edge with reset high has not been seen yet at the first negedge
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      if (i > 0) begin
        assert (dly_en == '0 && !cal_done && !cal_fail && !rd_valid_out)
          else flag_mismatch("outputs not idle during reset");
      end
    end
    @(posedge clk);
    #1;
    reset = 1'b0;

    // Count cycles from reset release to the first tap step
    cyc = 0;
    seen_rst = 1'b0;
    started = 1'b0;
    while (!started && cyc < settle_cycles + start_slack) begin
      @(negedge clk);
      cyc++;
      if (dly_rst == '1) seen_rst = 1'b1;
      if (dly_en != '0) started = 1'b1;
    end
    assert (seen_rst) else flag_mismatch("no dly_rst pulse after reset");
    if (!started) abort_run("Training never started: no tap step after the settle time");
    assert (cyc > settle_cycles) else flag_mismatch("tap step before the settle time elapsed");

    cyc = 0;
    while (!cal_done && cyc < cal_timeout) begin
      @(negedge clk);
      cyc++;
      if (bad_bit < 0) begin
        assert (!cal_fail) else flag_mismatch("cal_fail rose with all eyes in range");
      end
    end
    if (!cal_done) abort_run("Timeout while waiting for cal_done");

    if (bad_bit < 0) begin
      for (int b = 0; b < data_width; b++) begin
        tap = dly_model.taps[b];
        assert (tap < edge_pos[b] || (tap - edge_pos[b]) % (bit_steps + 1) != 0)
          else flag_mismatch($sformatf("bit %0d parked on an edge tap %0d", b, tap));
        assert (model_rise[b] != model_fall[b])
          else flag_mismatch($sformatf("bit %0d final tap %0d gives an invalid pair", b, tap));
        assert (aligned[b] == model_rise[b])
          else flag_mismatch($sformatf("bit %0d phase record %0b", b, aligned[b]));
      end
      exp_aligned = model_rise;
    end else begin
      assert (cal_fail) else flag_mismatch("cal_fail low with an eye out of range");
      assert (dly_model.taps[bad_bit] == 0)
        else flag_mismatch($sformatf("bit %0d not returned to tap 0", bad_bit));
    end
  endtask

  task automatic check_reads(input int n);
    logic [data_width-1:0] r1;
    logic [data_width-1:0] f1;
    logic [data_width-1:0] f2;
    logic [data_width-1:0] exp_rise;
    logic [data_width-1:0] exp_fall;
    logic v1;
    int r;
    r1 = '0;
    f1 = '0;
    f2 = '0;
    v1 = 1'b0;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
      use_model = 1'b0;
      random_bits(data_width, r);
      drv_rise = r[data_width-1:0];
      random_bits(data_width, r);
      drv_fall = r[data_width-1:0];
      random_bits(1, r);
      rd_valid_in = r[0];
      @(negedge clk);
      if (i >= 2) begin
        // A misaligned bit takes its first beat from the previous fall
        for (int b = 0; b < data_width; b++) begin
          exp_rise[b] = exp_aligned[b] ? r1[b] : f2[b];
          exp_fall[b] = exp_aligned[b] ? f1[b] : r1[b];
        end
        assert (rd_rise == exp_rise) else flag_mismatch("rd_rise mismatch");
        assert (rd_fall == exp_fall) else flag_mismatch("rd_fall mismatch");
        assert (rd_valid_out == v1) else flag_mismatch("rd_valid_out mismatch");
      end
      f2 = f1;
      r1 = drv_rise;
      f1 = drv_fall;
      v1 = rd_valid_in;
    end
  endtask

  initial begin
    int r;
    reset = 1'b1;
    rd_valid_in = 1'b0;
    use_model = 1'b1;
    drv_rise = '0;
    drv_fall = '0;
    exp_aligned = '0;
    lfsr = 32'h86c9;
    for (int b = 0; b < data_width; b++) begin
      edge_pos[b] = bit_steps + 1;
    end

    run_calibration(-1);
    check_reads(read_cycles);

    // Second run with one eye that the taps cannot reach
    random_bits(5, r);
    run_calibration(r % data_width);

    $display("sim passed");
    $finish;
  end

endmodule

// ==== testbench/qdr_delay_model.sv ====
`timescale 1ns/1ps

module qdr_delay_model import qdr_pkg::*; (
  input  logic                  clk,
  input  logic [data_width-1:0] dly_en,
  input  logic [data_width-1:0] dly_inc_dec_n,
  input  logic [data_width-1:0] dly_rst,
  input  int                    edge_pos [data_width],
  output logic [data_width-1:0] q_rise,
  output logic [data_width-1:0] q_fall
);

  // Current tap of each delay line
  int taps [data_width];

  // Captured pair {rise, fall} for a tap, given the eye edge of that bit
  function automatic logic [1:0] capture_pair(input int tap, input int edge_tap);
    int phase;
    if (tap < edge_tap) begin
      return 2'b01;
    end
    phase = (tap - edge_tap) % (bit_steps + 1);
    if (phase == 0) begin
      return 2'b11;
    end
    return 2'b10;
  endfunction

  initial begin
    for (int b = 0; b < data_width; b++) begin
      taps[b] = 0;
    end
  end

  // Tap controls are taken a little after the edge that launched them
  always @(posedge clk) begin
    #1;
    for (int b = 0; b < data_width; b++) begin
      if (dly_rst[b]) begin
        taps[b] = 0;
      end else if (dly_en[b]) begin
        if (dly_inc_dec_n[b] && taps[b] < tap_max) begin
          taps[b] = taps[b] + 1;
        end else if (!dly_inc_dec_n[b] && taps[b] > 0) begin
          taps[b] = taps[b] - 1;
        end
      end
    end
  end

  always_comb begin
    logic [1:0] pair;
    for (int b = 0; b < data_width; b++) begin
      pair = capture_pair(taps[b], edge_pos[b]);
      q_rise[b] = pair[1];
      q_fall[b] = pair[0];
    end
  end

endmodule

// ==== rtl/qdr_phy_cal.sv ====
`timescale 1ns/1ps

module qdr_phy_cal import qdr_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [data_width-1:0] q_rise,
  input  logic [data_width-1:0] q_fall,
  input  logic                  rd_valid_in,
  output logic [data_width-1:0] dly_en,
  output logic [data_width-1:0] dly_inc_dec_n,
  output logic [data_width-1:0] dly_rst,
  output logic                  cal_done,
  output logic                  cal_fail,
  output logic [data_width-1:0] aligned,
  output logic [data_width-1:0] rd_rise,
  output logic [data_width-1:0] rd_fall,
  output logic                  rd_valid_out
);

  // Training command and results between the sequencer and the trainer
  qdr_train_if train_bus ();

  qdr_cal_ctrl u_cal_ctrl (
    .clk      (clk),
    .reset    (reset),
    .tr       (train_bus.ctrl),
    .cal_done (cal_done),
    .cal_fail (cal_fail)
  );

  qdr_bit_train u_bit_train (
    .clk           (clk),
    .reset         (reset),
    .tr            (train_bus.train),
    .q_rise        (q_rise),
    .q_fall        (q_fall),
    .dly_en        (dly_en),
    .dly_inc_dec_n (dly_inc_dec_n),
    .dly_rst       (dly_rst)
  );

  // The phase record is also visible at the top for debug
  assign aligned = train_bus.aligned;

  qdr_read_align u_read_align (
    .clk          (clk),
    .reset        (reset),
    .cal_done     (cal_done),
    .aligned      (train_bus.aligned),
    .q_rise       (q_rise),
    .q_fall       (q_fall),
    .rd_valid_in  (rd_valid_in),
    .rd_rise      (rd_rise),
    .rd_fall      (rd_fall),
    .rd_valid_out (rd_valid_out)
  );

endmodule

// ==== rtl/qdr_read_align.sv ====
`timescale 1ns/1ps

module qdr_read_align import qdr_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cal_done,
  input  logic [data_width-1:0] aligned,
  input  logic [data_width-1:0] q_rise,
  input  logic [data_width-1:0] q_fall,
  input  logic                  rd_valid_in,
  output logic [data_width-1:0] rd_rise,
  output logic [data_width-1:0] rd_fall,
  output logic                  rd_valid_out
);

  // Fall sample of the previous cycle, which carries the first beat of a
  // misaligned bit
  logic [data_width-1:0] fall_prev;

  always_ff @(posedge clk) begin
    fall_prev <= q_fall;

    // Aligned bits pass straight through
    // Misaligned bits shift by half a clock, old fall becomes the rise beat
    rd_rise <= (q_rise & aligned) | (fall_prev & ~aligned);
    rd_fall <= (q_fall & aligned) | (q_rise & ~aligned);
  end

  // No read is reported before the phase record is complete
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid_out <= 1'b0;
    end else begin
      rd_valid_out <= rd_valid_in & cal_done;
    end
  end

endmodule

// ==== rtl/qdr_cal_ctrl.sv ====
`timescale 1ns/1ps

module qdr_cal_ctrl import qdr_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  qdr_train_if.ctrl  tr,
  output logic       cal_done,
  output logic       cal_fail
);

  cal_state_t state;
  logic [$clog2(settle_cycles)-1:0] settle_cnt;

  // The delay lines need settle_cycles clocks after reset before a tap
  // reading can be trusted, so training is held off until then
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= cal_settle;
      settle_cnt <= '0;
      cal_fail   <= 1'b0;
    end else begin
      // Any failing bit marks the whole calibration as failed
      if (tr.fail) begin
        cal_fail <= 1'b1;
      end

      case (state)
        cal_settle: begin
          if (settle_cnt == ($clog2(settle_cycles))'(settle_cycles - 1)) begin
            state <= cal_start;
          end else begin
            settle_cnt <= settle_cnt + 1'b1;
          end
        end

        cal_start: begin
          state <= cal_wait_train;
        end

        cal_wait_train: begin
          // Training time depends on where each eye lies
          if (tr.done) begin
            state <= cal_finished;
          end
        end

        cal_finished: begin
          state <= cal_finished;
        end

        default: begin
          state <= cal_settle;
        end
      endcase
    end
  end

  // Start lasts exactly the one cycle spent in cal_start
  assign tr.start = (state == cal_start);

  // Calibration stays complete until the next reset
  assign cal_done = (state == cal_finished);

endmodule

// ==== rtl/qdr_bit_train.sv ====
`timescale 1ns/1ps

module qdr_bit_train import qdr_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  qdr_train_if.train            tr,
  input  logic [data_width-1:0] q_rise,
  input  logic [data_width-1:0] q_fall,
  output logic [data_width-1:0] dly_en,
  output logic [data_width-1:0] dly_inc_dec_n,
  output logic [data_width-1:0] dly_rst
);

  // A captured pair only carries a usable bit when rise and fall differ
  function automatic logic is_valid(input logic [1:0] pair);
    return pair[1] ^ pair[0];
  endfunction

  train_state_t state;
  logic acquiring;
  logic rst_pending;

  logic [index_width-1:0] bit_index;
  logic [tap_width-1:0] progress;
  logic [tap_width-1:0] baddies;
  logic [tap_width-1:0] edge_tap;
  logic [acq_width-1:0] acq_cnt;

  logic [1:0] sync1;
  logic [1:0] sync2;
  logic [1:0] curr;
  logic [1:0] prev;
  logic [1:0] hist0;
  logic [1:0] hist1;
  logic [1:0] hist2;
  logic history_stable;

  // Bad samples were counted from the first tap past the edge
  assign edge_tap = progress - baddies;

  // The last four acquired readings agree
  assign history_stable = (curr == hist0) && (hist0 == hist1) && (hist1 == hist2);

  // Two-stage capture of the bit under training, it crosses from the IDDR domain
  always_ff @(posedge clk) begin
    sync1 <= {q_rise[bit_index], q_fall[bit_index]};
    sync2 <= sync1;
  end

  always_ff @(posedge clk) begin
    // Tap steps and delay resets are one-cycle strobes
    dly_en  <= '0;
    dly_rst <= '0;

    if (reset) begin
      state         <= train_idle;
      acquiring     <= 1'b0;
      rst_pending   <= 1'b1;
      dly_inc_dec_n <= '0;
      bit_index     <= '0;
      progress      <= '0;
      baddies       <= '0;
      acq_cnt       <= '0;
      curr          <= 2'b00;
      prev          <= 2'b00;
      hist0         <= 2'b00;
      hist1         <= 2'b00;
      hist2         <= 2'b00;
      tr.done       <= 1'b0;
      tr.fail       <= 1'b0;
      tr.aligned    <= '1;
    end else begin
      // All delay lines start from tap 0 after reset
      if (rst_pending) begin
        dly_rst <= '1;
      end
      rst_pending <= 1'b0;

      if (acquiring) begin
        // The first samples still show the tap before the last step
        if (acq_cnt < acq_width'(capture_lag)) begin
          acq_cnt <= acq_cnt + 1'b1;
        end else if (!is_valid(sync2) ||
                     (acq_cnt != acq_width'(capture_lag) && sync2 != curr)) begin
          curr      <= 2'b00;
          acquiring <= 1'b0;
        end else begin
          curr    <= sync2;
          acq_cnt <= acq_cnt + 1'b1;
          if (acq_cnt == acq_width'(capture_lag + acquire_threshold - 1)) begin
            acquiring <= 1'b0;
          end
        end
      end else begin
        case (state)
          train_idle: begin
            if (tr.start) begin
              state     <= train_search;
              acquiring <= 1'b1;
              acq_cnt   <= '0;
              progress  <= '0;
              baddies   <= '0;
              prev      <= 2'b00;
              hist0     <= 2'b00;
              hist1     <= 2'b00;
              hist2     <= 2'b00;
            end
          end

          train_search: begin
            hist0 <= curr;
            hist1 <= hist0;
            hist2 <= hist1;

            if (curr != prev && is_valid(curr) && is_valid(prev) && history_stable) begin
              // Centre on the eye below the edge if a whole bit fits there
              if (edge_tap > tap_width'(bit_steps)) begin
                state    <= train_back;
                progress <= baddies + tap_width'(half_bit);
              end else begin
                state <= train_forward;
                if (baddies < tap_width'(half_bit)) begin
                  progress <= tap_width'(half_bit) - baddies;
                end else begin
                  progress <= '0;
                end
              end
            end else if (progress == tap_width'(tap_max)) begin
              // Out of taps with no edge seen, park this bit at tap 0
              state              <= train_align;
              progress           <= tap_width'(align_wait);
              tr.fail            <= 1'b1;
              dly_rst[bit_index] <= 1'b1;
            end else begin
              acquiring                <= 1'b1;
              acq_cnt                  <= '0;
              progress                 <= progress + 1'b1;
              dly_inc_dec_n[bit_index] <= 1'b1;
              dly_en[bit_index]        <= 1'b1;

              if (is_valid(curr) && history_stable) begin
                prev <= curr;
              end

              // Once the reading leaves the old eye every further tap is counted
              if (baddies != '0 || (is_valid(prev) && curr != prev)) begin
                baddies <= baddies + 1'b1;
              end
            end
          end

          train_back, train_forward: begin
            hist0 <= curr;
            hist1 <= hist0;
            hist2 <= hist1;

            if (progress != '0) begin
              acquiring                <= 1'b1;
              acq_cnt                  <= '0;
              progress                 <= progress - 1'b1;
              dly_inc_dec_n[bit_index] <= (state == train_forward);
              dly_en[bit_index]        <= 1'b1;
            end else begin
              state    <= train_align;
              progress <= tap_width'(align_wait);
              // The final tap must sit on a clean, settled reading
              if (!is_valid(curr) || !history_stable) begin
                tr.fail <= 1'b1;
              end
            end
          end

          train_align: begin
            if (progress != '0) begin
              progress <= progress - 1'b1;
            end else begin
              state <= train_done;
              if (!sync2[1]) begin
                tr.aligned[bit_index] <= 1'b0;
              end
            end
          end

          train_done: begin
            if (bit_index < index_width'(data_width - 1)) begin
              state     <= train_search;
              bit_index <= bit_index + 1'b1;
              acquiring <= 1'b1;
              acq_cnt   <= '0;
              progress  <= '0;
              baddies   <= '0;
              prev      <= 2'b00;
              hist0     <= 2'b00;
              hist1     <= 2'b00;
              hist2     <= 2'b00;
            end else begin
              tr.done <= 1'b1;
            end
          end

          default: begin
            state <= train_idle;
          end
        endcase
      end
    end
  end

endmodule

// ==== rtl/qdr_train_if.sv ====
`timescale 1ns/1ps

interface qdr_train_if import qdr_pkg::*; ();

  // Single-cycle request from the sequencer
  logic start;

  // Sticky until reset
  logic done;
  logic fail;

  // One bit per data line, low when the rise sample holds the second beat
  logic [data_width-1:0] aligned;

  modport ctrl (
    output start,
    input  done,
    input  fail
  );

  modport train (
    input  start,
    output done,
    output fail,
    output aligned
  );

endinterface

// ==== rtl/qdr_pkg.sv ====
package qdr_pkg;

  // Read data bus of the QDR device
  localparam int data_width = 18;
  localparam int index_width = $clog2(data_width);

  // Input delay line geometry, in taps
  localparam int tap_max = 63;
  localparam int tap_width = $clog2(tap_max + 1);
  localparam int bit_steps = 7;
  localparam int half_bit = (bit_steps + 1) / 2;

  // Sampling of the captured pair during training
  localparam int acquire_threshold = 16;
  localparam int capture_lag = 3;
  localparam int acq_width = $clog2(capture_lag + acquire_threshold + 1);
  localparam int align_wait = 4;

  // Delay line settling time after reset
  localparam int settle_cycles = 32;

  typedef enum logic [2:0] {
    train_idle,
    train_search,
    train_back,
    train_forward,
    train_align,
    train_done
  } train_state_t;

  typedef enum logic [1:0] {
    cal_settle,
    cal_start,
    cal_wait_train,
    cal_finished
  } cal_state_t;

endpackage
